/* files.f */
+incdir+rtl
rtl/hifPkg.sv
rtl/clientPkg.sv
rtl/portArbiter.sv
rtl/hifAddrGen.sv
rtl/hifReqDriver.sv
rtl/rdWrCtlr.sv
verif/rdWrChecker.sv
verif/tbRdWrCtlr.sv

/* run.sh */
#!/bin/sh
# Build and run the read/write controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tbRdWrCtlr -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/VtbRdWrCtlr)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

/* verif/tbRdWrCtlr.sv */
// Testbench top: clock, reset, host bus model, client stimulus, watchdog and closing report
`timescale 1ns/100ps
`include "rdWrCtlr_defines.svh"

module tbRdWrCtlr;

  import clientPkg::*;
  import hifPkg::*;

  localparam int NumRounds = 3;
  localparam int NumTests  = NumRounds * 4;                 // Four bursts per round
  localparam int MaxBurst  = 8;
  localparam int ClkPeriod = 100;
  localparam int TimeoutNs = NumTests * MaxBurst * 20 * ClkPeriod;

  logic       macPIClk;
  logic       macPIClkHardRst_n;
  listReq_t   rxReq;
  listReq_t   txReq;
  staReq_t    staReq;
  hifRsp_t    hifRsp;
  hifCmd_t    hifCmd;
  clientRsp_t rxRsp;
  clientRsp_t txRsp;
  clientRsp_t staRsp;
  logic       rdWrCtlrIdle;
  int         mismatchCount;
  int         ruleCount;
  int         burstLen;       // Beats before transComplete
  int         beats;          // Beats taken so far
  int         errBeat;        // Beat with error, 0 for none
  logic       doneSent;       // transComplete already given

  rdWrCtlr dut_i (.macPIClk, .macPIClkHardRst_n, .rxReq, .txReq, .staReq, .hifRsp, .hifCmd,
                  .rxRsp, .txRsp, .staRsp, .rdWrCtlrIdle);

  rdWrChecker chk_i (.macPIClk, .macPIClkHardRst_n, .rxReq, .txReq, .staReq, .hifRsp, .hifCmd,
                     .rxRsp, .txRsp, .staRsp, .rdWrCtlrIdle, .mismatchCount, .ruleCount);

  initial
  begin
    macPIClk = 1'b0;
    forever #(ClkPeriod / 2) macPIClk = ~macPIClk;
  end

  // Slave memory pattern
  function automatic logic [`RDWR_DATA_W-1:0] memWord(input logic [`RDWR_ADDR_W-1:0] addr);
    return {addr[15:0], addr[31:16]} ^ (addr << 3) ^ 32'hC3A5_5A3C;
  endfunction

  function automatic hifSize_e randSize();
    case ($urandom_range(0, 2))
      0:       return SIZE_BYTE;
      1:       return SIZE_HALF;
      default: return SIZE_WORD;
    endcase
  endfunction

  //////////////////////////////
  // Bus model and clients
  //////////////////////////////
  // Falling edge; bus answers first, then clients move on after a taken beat
  task automatic nextCycle();
    logic beatTaken;
    @(negedge macPIClk);
    beatTaken = hifRsp.ready;
    hifRsp    = '0;
    if (!doneSent && (hifCmd.read || hifCmd.write))
    begin
      if (beats == burstLen)
      begin
        hifRsp.transComplete = 1'b1;                    // Burst end
        doneSent             = 1'b1;
      end
      else if ($urandom_range(0, 3) != 0)               // Random back-pressure
      begin
        beats++;
        hifRsp.ready = 1'b1;
        hifRsp.error = (beats == errBeat);
        if (hifCmd.read)
        begin
          hifRsp.readDataValid = 1'b1;
          hifRsp.readDataOut   = memWord(hifCmd.addressIn);
        end
      end
    end
    if (beatTaken)
    begin
      rxReq.writeData  = $urandom;                      // Next word
      txReq.writeData  = $urandom;
      staReq.writeData = $urandom;
    end
  endtask

  // One access from request to idle
  task automatic runBurst(input portSel_e port, input logic isRead, input int len,
                          input logic withError);
    logic [`RDWR_ADDR_W-1:0] addr;
    addr     = ($urandom & 32'h0FFF_FFFF) | 32'h0000_0100;   // Never zero when aligned
    burstLen = len;
    beats    = 0;
    doneSent = 1'b0;
    errBeat  = withError ? $urandom_range(1, len) : 0;
    case (port)
      PORT_RX: rxReq = '{startAddress: addr, read: isRead, write: !isRead, size: randSize(),
                         writeData: $urandom, last: 1'b0};
      PORT_TX: txReq = '{startAddress: addr, read: isRead, write: !isRead, size: randSize(),
                         writeData: $urandom, last: 1'b0};
      default: staReq = '{startAddress: addr, write: 1'b1, writeData: $urandom};
    endcase
    nextCycle();
    while (!doneSent)
      nextCycle();
    nextCycle();
    if (isRead)
    begin
      rxReq.last = (port == PORT_RX);                   // Strobe must stay low
      txReq.last = (port == PORT_TX);
      repeat (2) nextCycle();
    end
    rxReq  = '0;
    txReq  = '0;
    staReq = '0;
    nextCycle();
    while (!rdWrCtlrIdle)
      nextCycle();
    repeat (2) nextCycle();                             // Gap between accesses
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    void'($urandom(56530));
    macPIClkHardRst_n = 1'b0;
    rxReq    = '0;
    txReq    = '0;
    staReq   = '0;
    hifRsp   = '0;
    burstLen = 0;
    beats    = 0;
    errBeat  = 0;
    doneSent = 1'b1;                                    // Bus quiet
    repeat (2) @(negedge macPIClk);
    macPIClkHardRst_n = 1'b1;
    repeat (2) nextCycle();
    for (int r = 0; r < NumRounds; r++)
    begin
      runBurst(PORT_RX, 1'b1, $urandom_range(2, MaxBurst), 1'b0);   // rx read
      runBurst(PORT_TX, 1'b0, $urandom_range(2, MaxBurst), 1'b0);   // tx write
      runBurst(PORT_STA, 1'b0, 1, 1'b0);                            // Single status word
      case (r % 3)                                                  // Error injection
        0:       runBurst(PORT_TX, 1'b1, $urandom_range(2, MaxBurst), 1'b1);
        1:       runBurst(PORT_RX, 1'b0, $urandom_range(2, MaxBurst), 1'b1);
        default: runBurst(PORT_STA, 1'b0, 1, 1'b1);
      endcase
    end
    $display("Closing report: %0d value mismatches, %0d rule violations",
             mismatchCount, ruleCount);
    if (mismatchCount == 0 && ruleCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TimeoutNs);
    $display("Timeout: the tests did not finish within %0d ns", TimeoutNs);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* verif/rdWrChecker.sv */
// Checker with reference read data, expected controller model and per-cycle port comparison
`timescale 1ns/100ps
`include "rdWrCtlr_defines.svh"

module rdWrChecker
(
  input  logic                   macPIClk,
  input  logic                   macPIClkHardRst_n,
  input  clientPkg::listReq_t    rxReq,
  input  clientPkg::listReq_t    txReq,
  input  clientPkg::staReq_t     staReq,
  input  hifPkg::hifRsp_t        hifRsp,
  input  hifPkg::hifCmd_t        hifCmd,
  input  clientPkg::clientRsp_t  rxRsp,
  input  clientPkg::clientRsp_t  txRsp,
  input  clientPkg::clientRsp_t  staRsp,
  input  logic                   rdWrCtlrIdle,
  output int                     mismatchCount,  // Wrong values
  output int                     ruleCount       // Protocol rule breaks
);

  import clientPkg::*;
  import hifPkg::*;

  portSel_e                expSel;     // Expected owner
  logic [`RDWR_ADDR_W-1:0] expAddr;    // Expected burst address
  logic                    readLvl;    // Read level one cycle ago
  logic                    writeLvl;

  // Memory contents returned for any address
  function automatic logic [`RDWR_DATA_W-1:0] refData(input logic [`RDWR_ADDR_W-1:0] addr);
    return {addr[15:0], addr[31:16]} ^ (addr << 3) ^ 32'hC3A5_5A3C;
  endfunction

  // Owner sees the bus response and all others see zeros
  function automatic clientRsp_t expectRsp(input portSel_e port, input logic canRead,
                                           input logic readHeld);
    clientRsp_t rsp;
    rsp = '0;
    if (expSel == port)
    begin
      rsp.error         = hifRsp.error;
      rsp.nextData      = hifRsp.ready;           // Mirrors ready
      rsp.transComplete = hifRsp.transComplete;
      if (canRead)
      begin
        rsp.readData      = hifRsp.readDataOut;
        rsp.readDataValid = hifRsp.readDataValid & readHeld;
      end
    end
    return rsp;
  endfunction

  function automatic int compareValue(input string sigName, input logic [63:0] expVal,
                                      input logic [63:0] actVal);
    if (expVal === actVal)
      return 0;
    $display("[FAIL] %0t ns %s expected %0h got %0h", $time, sigName, expVal, actVal);
    return 1;
  endfunction

  //////////////////////////////
  // Compare and then advance model
  //////////////////////////////
  always @(posedge macPIClk or negedge macPIClkHardRst_n)
  begin : compareProc
    logic                    wReq;
    logic                    rReq;
    logic                    lastAny;
    logic [`RDWR_DATA_W-1:0] expData;
    hifSize_e                expSize;
    portSel_e                winner;
    if (!macPIClkHardRst_n)
    begin
      expSel        = PORT_NONE;
      expAddr       = '0;
      readLvl       = 1'b0;
      writeLvl      = 1'b0;
      mismatchCount = 0;
      ruleCount     = 0;
    end
    else
    begin
      wReq    = rxReq.write | txReq.write | staReq.write;
      rReq    = rxReq.read | txReq.read;
      lastAny = rxReq.last | txReq.last;
      mismatchCount += compareValue("hifCmd.addressIn", 64'(expAddr), 64'(hifCmd.addressIn));
      mismatchCount += compareValue("hifCmd.read", 64'(readLvl & rReq & ~lastAny),
                                    64'(hifCmd.read));
      mismatchCount += compareValue("hifCmd.write", 64'(writeLvl & (rxReq.write | txReq.write
                                    | (staReq.write & (expSel == PORT_STA)))), 64'(hifCmd.write));
      case (expSel)
        PORT_RX:  expData = rxReq.writeData;
        PORT_TX:  expData = txReq.writeData;
        PORT_STA: expData = staReq.writeData;
        default:  expData = '0;
      endcase
      case (expSel)
        PORT_RX:  expSize = rxReq.size;
        PORT_TX:  expSize = txReq.size;
        PORT_STA: expSize = SIZE_WORD;
        default:  expSize = SIZE_BYTE;
      endcase
      if (hifCmd.write)                                   // Write beat fields
      begin
        mismatchCount += compareValue("hifCmd.writeData", 64'(expData), 64'(hifCmd.writeData));
        mismatchCount += compareValue("hifCmd.size", 64'(expSize), 64'(hifCmd.size));
      end
      mismatchCount += compareValue("rxRsp", 64'(expectRsp(PORT_RX, 1'b1, rReq)), 64'(rxRsp));
      mismatchCount += compareValue("txRsp", 64'(expectRsp(PORT_TX, 1'b1, rReq)), 64'(txRsp));
      mismatchCount += compareValue("staRsp", 64'(expectRsp(PORT_STA, 1'b0, rReq)), 64'(staRsp));
      if (rxRsp.readDataValid)
        mismatchCount += compareValue("rxRsp.readData", 64'(refData(expAddr)),
                                      64'(rxRsp.readData));
      if (txRsp.readDataValid)
        mismatchCount += compareValue("txRsp.readData", 64'(refData(expAddr)),
                                      64'(txRsp.readData));
      mismatchCount += compareValue("rdWrCtlrIdle", 64'(!(wReq || rReq || (expSel != PORT_NONE))),
                                    64'(rdWrCtlrIdle));
      if (lastAny && hifCmd.read)
      begin
        $display("Read strobe was high at %0t ns while a list client held last", $time);
        ruleCount++;
      end
      // Next state with writes winning over reads
      winner = PORT_NONE;
      if (wReq && !writeLvl)
        winner = rxReq.write ? PORT_RX : (txReq.write ? PORT_TX : PORT_STA);
      else if (rReq && !readLvl)
        winner = rxReq.read ? PORT_RX : PORT_TX;
      if (winner != PORT_NONE)
      begin
        expSel = winner;
        case (winner)
          PORT_RX: expAddr = {rxReq.startAddress[31:2], 2'b00};
          PORT_TX: expAddr = {txReq.startAddress[31:2], 2'b00};
          default: expAddr = {staReq.startAddress[31:2], 2'b00};
        endcase
      end
      else
      begin
        if (hifRsp.transComplete)
          expSel = PORT_NONE;                             // Release
        if (!(readLvl || writeLvl))
          expAddr = '0;
        else if (hifRsp.ready)
          expAddr = expAddr + `RDWR_WORD_STEP;            // One word per beat
      end
      readLvl  = rReq;
      writeLvl = wReq;
    end
  end

endmodule

/* rtl/rdWrCtlr.sv */
// Read/write controller top: arbiter, address generator and request driver wiring
`timescale 1ns/100ps
`include "rdWrCtlr_defines.svh"

module rdWrCtlr
(
  input  logic                   macPIClk,
  input  logic                   macPIClkHardRst_n,
  input  clientPkg::listReq_t    rxReq,
  input  clientPkg::listReq_t    txReq,
  input  clientPkg::staReq_t     staReq,
  input  hifPkg::hifRsp_t        hifRsp,
  output hifPkg::hifCmd_t        hifCmd,
  output clientPkg::clientRsp_t  rxRsp,
  output clientPkg::clientRsp_t  txRsp,
  output clientPkg::clientRsp_t  staRsp,
  output logic                   rdWrCtlrIdle
);

  import clientPkg::*;
  import hifPkg::*;

  logic                    accessStart;
  portSel_e                startPort;
  portSel_e                activeSel;
  logic                    readActive;
  logic                    writeActive;
  logic [`RDWR_ADDR_W-1:0] hifAddr;
  logic                    hifRead;
  logic                    hifWrite;
  hifSize_e                hifSize;
  logic [`RDWR_DATA_W-1:0] hifWrData;

  //////////////////////////////
  // Blocks
  //////////////////////////////
  portArbiter arb_i (.macPIClk, .macPIClkHardRst_n, .rxReq, .txReq, .staReq, .hifRsp,
                     .rxRsp, .txRsp, .staRsp, .accessStart, .startPort, .activeSel,
                     .readActive, .writeActive, .rdWrCtlrIdle);

  hifAddrGen addrGen_i (.macPIClk, .macPIClkHardRst_n, .accessStart, .startPort,
                        .rxAddr(rxReq.startAddress), .txAddr(txReq.startAddress),
                        .staAddr(staReq.startAddress), .readActive, .writeActive,
                        .ready(hifRsp.ready), .addressIn(hifAddr));

  hifReqDriver reqDrv_i (.rxReq, .txReq, .staWriteData(staReq.writeData), .activeSel,
                         .readActive, .writeActive, .read(hifRead), .write(hifWrite),
                         .size(hifSize), .writeData(hifWrData));

  // Pack host bus command
  assign hifCmd = '{addressIn: hifAddr,
                    read:      hifRead,
                    write:     hifWrite,
                    size:      hifSize,
                    writeData: hifWrData};

  // Read strobe only after the start address was loaded
  noReadAtAddr0: assert property (@(posedge macPIClk) disable iff (!macPIClkHardRst_n)
    hifCmd.read |-> (hifCmd.addressIn != '0));

endmodule

/* rtl/hifReqDriver.sv */
// HIF request driver: write data and size mux, read and write strobe generation
`timescale 1ns/100ps
`include "rdWrCtlr_defines.svh"

module hifReqDriver
(
  input  clientPkg::listReq_t       rxReq,
  input  clientPkg::listReq_t       txReq,
  input  logic [`RDWR_DATA_W-1:0]   staWriteData,
  input  clientPkg::portSel_e       activeSel,
  input  logic                      readActive,
  input  logic                      writeActive,
  output logic                      read,
  output logic                      write,
  output hifPkg::hifSize_e          size,
  output logic [`RDWR_DATA_W-1:0]   writeData
);

  import clientPkg::*;
  import hifPkg::*;

  logic liveRead;
  logic liveWrite;
  logic lastAccess;

  //////////////////////////////
  // Data and size mux
  //////////////////////////////
  always_comb
  begin
    case (activeSel)
      PORT_RX:
      begin
        writeData = rxReq.writeData;
        size      = rxReq.size;
      end
      PORT_TX:
      begin
        writeData = txReq.writeData;
        size      = txReq.size;
      end
      PORT_STA:
      begin
        writeData = staWriteData;
        size      = SIZE_WORD;            // Status always one word
      end
      default:
      begin
        writeData = '0;
        size      = SIZE_BYTE;            // Encodes as zero
      end
    endcase
  end

  //////////////////////////////
  // Strobes
  //////////////////////////////
  assign lastAccess = rxReq.last | txReq.last;
  assign liveRead   = rxReq.read | txReq.read;
  // staUpd level stands in as ownership, released with its transComplete
  assign liveWrite  = rxReq.write | txReq.write | (activeSel == PORT_STA);

  assign read  = readActive & liveRead & ~lastAccess;   // One cycle after request
  assign write = writeActive & liveWrite;

endmodule

/* rtl/hifAddrGen.sv */
// Burst address generator: aligned start address capture and per-beat increment
`timescale 1ns/100ps
`include "rdWrCtlr_defines.svh"

module hifAddrGen
(
  input  logic                      macPIClk,
  input  logic                      macPIClkHardRst_n,
  input  logic                      accessStart,
  input  clientPkg::portSel_e       startPort,
  input  logic [`RDWR_ADDR_W-1:0]   rxAddr,
  input  logic [`RDWR_ADDR_W-1:0]   txAddr,
  input  logic [`RDWR_ADDR_W-1:0]   staAddr,
  input  logic                      readActive,
  input  logic                      writeActive,
  input  logic                      ready,          // HIF beat accepted
  output logic [`RDWR_ADDR_W-1:0]   addressIn
);

  import clientPkg::*;

  localparam logic [`RDWR_ADDR_W-1:0] WordStep = `RDWR_ADDR_W'(`RDWR_WORD_STEP);

  // Clear byte offset within a word
  function automatic logic [`RDWR_ADDR_W-1:0] alignWord(input logic [`RDWR_ADDR_W-1:0] addr);
    return addr & ~(WordStep - 1'b1);
  endfunction

  //////////////////////////////
  // Address register
  //////////////////////////////
  always_ff @(posedge macPIClk or negedge macPIClkHardRst_n)
  begin
    if (!macPIClkHardRst_n)
      addressIn <= '0;
    else if (accessStart)
    begin
      // Load start address of the winner
      case (startPort)
        PORT_RX:  addressIn <= alignWord(rxAddr);
        PORT_TX:  addressIn <= alignWord(txAddr);
        PORT_STA: addressIn <= alignWord(staAddr);
        default:  addressIn <= addressIn;
      endcase
    end
    else if (readActive || writeActive)
    begin
      if (ready)
        addressIn <= addressIn + WordStep;   // Next beat
    end
    else
      addressIn <= '0;                       // Idle
  end

endmodule

/* rtl/portArbiter.sv */
// Port arbiter with request edge detection, active port register, idle flag and response routing
`timescale 1ns/100ps

module portArbiter
(
  input  logic                   macPIClk,
  input  logic                   macPIClkHardRst_n,
  input  clientPkg::listReq_t    rxReq,
  input  clientPkg::listReq_t    txReq,
  input  clientPkg::staReq_t     staReq,
  input  hifPkg::hifRsp_t        hifRsp,
  output clientPkg::clientRsp_t  rxRsp,
  output clientPkg::clientRsp_t  txRsp,
  output clientPkg::clientRsp_t  staRsp,
  output logic                   accessStart,  // First cycle of an access
  output clientPkg::portSel_e    startPort,    // Winner, valid with accessStart
  output clientPkg::portSel_e    activeSel,    // Registered owner
  output logic                   readActive,   // Registered read level
  output logic                   writeActive,  // Registered write level
  output logic                   rdWrCtlrIdle
);

  import clientPkg::*;

  logic writeReq;     // Any live write level
  logic readReq;      // Any live read level
  logic writeStart;
  logic readStart;

  //////////////////////////////
  // Request detection
  //////////////////////////////
  assign writeReq   = rxReq.write | txReq.write | staReq.write;
  assign readReq    = rxReq.read | txReq.read;     // staUpd never reads
  assign writeStart = writeReq & ~writeActive;     // Rising level
  assign readStart  = readReq & ~readActive;
  assign accessStart = writeStart | readStart;

  always_ff @(posedge macPIClk or negedge macPIClkHardRst_n)
  begin
    if (!macPIClkHardRst_n)
    begin
      writeActive <= 1'b0;
      readActive  <= 1'b0;
    end
    else
    begin
      writeActive <= writeReq;
      readActive  <= readReq;
    end
  end

  // Writes first, then rx, tx, staUpd inside each class
  always_comb
  begin
    startPort = PORT_NONE;
    if (writeStart)
    begin
      if (rxReq.write)
        startPort = PORT_RX;
      else if (txReq.write)
        startPort = PORT_TX;
      else
        startPort = PORT_STA;
    end
    else if (readStart)
    begin
      if (rxReq.read)
        startPort = PORT_RX;
      else
        startPort = PORT_TX;
    end
  end

  //////////////////////////////
  // Active port
  //////////////////////////////
  always_ff @(posedge macPIClk or negedge macPIClkHardRst_n)
  begin
    if (!macPIClkHardRst_n)
      activeSel <= PORT_NONE;
    else if (accessStart)
      activeSel <= startPort;                 // New start wins over release
    else if (hifRsp.transComplete)
      activeSel <= PORT_NONE;                 // Release after burst end
  end

  assign rdWrCtlrIdle = ~(writeReq | readReq | (activeSel != PORT_NONE));

  //////////////////////////////
  // Response routing
  //////////////////////////////
  // Zeros unless this client owns the bus
  function automatic clientRsp_t routeRsp(input portSel_e port, input logic canRead);
    clientRsp_t rsp;
    rsp = '0;
    if (activeSel == port)
    begin
      rsp.error         = hifRsp.error;
      rsp.nextData      = hifRsp.ready;
      rsp.transComplete = hifRsp.transComplete;
      if (canRead)
      begin
        rsp.readData      = hifRsp.readDataOut;
        rsp.readDataValid = hifRsp.readDataValid & readReq;  // Only during a read
      end
    end
    return rsp;
  endfunction

  always_comb
  begin
    rxRsp  = routeRsp(PORT_RX, 1'b1);
    txRsp  = routeRsp(PORT_TX, 1'b1);
    staRsp = routeRsp(PORT_STA, 1'b0);    // Write-only client
  end

  // Client protocol checks
  writeNotRead: assert property (@(posedge macPIClk) disable iff (!macPIClkHardRst_n)
    writeActive |-> !readActive);
  listReadsExcl: assert property (@(posedge macPIClk) disable iff (!macPIClkHardRst_n)
    rxReq.read |-> !txReq.read);
  writesExcl: assert property (@(posedge macPIClk) disable iff (!macPIClkHardRst_n)
    $onehot0({rxReq.write, txReq.write, staReq.write}));

endmodule

/* rtl/clientPkg.sv */
// Client port types: port selection enum, request and response structs
`include "rdWrCtlr_defines.svh"

package clientPkg;

  // Currently owning client
  typedef enum logic [1:0]
  {
    PORT_NONE = 2'd0,
    PORT_RX   = 2'd1,
    PORT_TX   = 2'd2,
    PORT_STA  = 2'd3
  } portSel_e;

  // rxList / txList request, levels held for the whole access
  typedef struct packed
  {
    logic [`RDWR_ADDR_W-1:0] startAddress;   // Byte address, low bits ignored
    logic                    read;           // Read request level
    logic                    write;          // Write request level
    hifPkg::hifSize_e        size;           // Access size
    logic [`RDWR_DATA_W-1:0] writeData;      // Current write word
    logic                    last;           // Last read beat, stops the strobe
  } listReq_t;

  // Status updater request, write only
  typedef struct packed
  {
    logic [`RDWR_ADDR_W-1:0] startAddress;
    logic                    write;
    logic [`RDWR_DATA_W-1:0] writeData;
  } staReq_t;

  // Response seen by a client
  // staUpd only looks at error, nextData and transComplete
  typedef struct packed
  {
    logic                    error;          // Transfer error
    logic                    nextData;       // Beat taken, present next word
    logic [`RDWR_DATA_W-1:0] readData;       // Read word
    logic                    readDataValid;  // Read word valid
    logic                    transComplete;  // Access done
  } clientRsp_t;

endpackage

/* rtl/hifPkg.sv */
// Host bus types: access size enum, command and response structs
`include "rdWrCtlr_defines.svh"

package hifPkg;

  // AHB HSIZE encoding
  typedef enum logic [`RDWR_SIZE_W-1:0]
  {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = `RDWR_STA_SIZE    // Also the fixed status size
  } hifSize_e;

  // Command toward the AHB master
  typedef struct packed
  {
    logic [`RDWR_ADDR_W-1:0] addressIn;      // Start or current burst address
    logic                    read;           // Read strobe
    logic                    write;          // Write strobe
    hifSize_e                size;           // Beat size
    logic [`RDWR_DATA_W-1:0] writeData;      // Data for the current beat
  } hifCmd_t;

  // Response from the AHB master
  typedef struct packed
  {
    logic                    error;          // Bus error response
    logic [`RDWR_DATA_W-1:0] readDataOut;    // Read beat data
    logic                    readDataValid;  // Read beat valid
    logic                    ready;          // Beat accepted, push next one
    logic                    transComplete;  // Burst finished
  } hifRsp_t;

endpackage

/* rtl/rdWrCtlr_defines.svh */
// Bus width, word step and status access size macros for the read/write controller
`ifndef RDWR_CTLR_DEFINES_SVH
`define RDWR_CTLR_DEFINES_SVH

// Host bus widths
`define RDWR_ADDR_W     32        // Byte address
`define RDWR_DATA_W     32        // One data word
`define RDWR_SIZE_W     3         // AHB HSIZE encoding

// Burst stepping
`define RDWR_WORD_STEP  4         // Bytes per beat, always a full word

// Status updater accesses are fixed to one word
`define RDWR_STA_SIZE   3'b010

`endif
